//--- logic/snappy_pkg.sv
`default_nettype none

package snappy_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// sizes
	localparam int BEAT_BYTES      = 16;          // bytes per input beat
	localparam int LOOKAHEAD_BYTES = 2;           // borrowed from the next beat
	localparam int SLICE_BYTES     = BEAT_BYTES + LOOKAHEAD_BYTES;
	localparam int LEN_W           = 35;          // stream length in bytes
	localparam int BEAT_CNT_W      = LEN_W - 4;   // beats per stream
	localparam int ADDR_W          = 17;          // decompressed address, wraps
	localparam int TOK_LEN_W       = 9;           // output bytes of one token in a slice
	localparam int LIT_CARRY_W     = 16;          // literal bytes spilling onward
	localparam int LIT_IN_W        = 5;           // carried literal bytes inside one slice
	localparam int SUM_W           = 13;          // output bytes of a whole slice

	// tag encodings
	localparam logic [7:0] TAG_LIT_LEN1 = 8'hF0;  // length in the following byte
	localparam logic [1:0] TAG_COPY1    = 2'b01;  // one-byte offset
	localparam logic [1:0] TAG_COPY2    = 2'b10;  // two-byte offset

	//////////////////////////////////////////////////////////////////////////////
	// scalar types
	typedef logic [BEAT_BYTES*8-1:0]  beat_t;        // byte 0 in the top bits
	typedef logic [SLICE_BYTES*8-1:0] slice_data_t;
	typedef logic [BEAT_BYTES-1:0]    pos_mask_t;    // msb = byte 0
	typedef logic [LEN_W-1:0]         stream_len_t;
	typedef logic [ADDR_W-1:0]        addr_t;

	// guess for one byte, as if a token started there
	typedef struct packed {
		logic [TOK_LEN_W-1:0]   out_len;     // output bytes counted in this slice
		pos_mask_t              next_mask;   // bytes owned by this token
		logic [LIT_CARRY_W-1:0] lit_carry;   // literal bytes past byte 15
	} tok_guess_t;

	typedef struct packed {
		slice_data_t data;
		pos_mask_t   end_mask;   // zeros past the stream end
	} formed_slice_t;

	typedef struct packed {
		formed_slice_t                slc;
		tok_guess_t [BEAT_BYTES-1:0]  guess;   // index = byte
	} decoded_slice_t;

	typedef struct packed {
		slice_data_t                           data;
		pos_mask_t                             token_pos;
		logic                                  start_lit;
		logic [LIT_IN_W-1:0]                   lit_in_slice;
		logic [BEAT_BYTES-1:0][TOK_LEN_W-1:0]  out_len;   // index = byte
	} resolved_slice_t;

	typedef struct packed {
		slice_data_t data;
		pos_mask_t   token_pos;
		logic        start_lit;
		addr_t       address;
	} slice_out_t;

	// tag plus length bytes of a token
	function automatic logic [1:0] tag_bytes(input logic [7:0] tag);
		if (tag == TAG_LIT_LEN1 || tag[1:0] == TAG_COPY1) begin
			return 2'd2;
		end
		if (tag[1:0] == TAG_COPY2) begin
			return 2'd3;
		end
		return 2'd1;   // literal with length in the tag
	endfunction

endpackage

`default_nettype wire

//--- logic/slice_former.sv
`timescale 1ns/10ps
`default_nettype none

module slice_former (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire snappy_pkg::beat_t        in_beat,
	input  wire logic                     in_valid,
	input  wire logic                     start,
	input  wire snappy_pkg::stream_len_t  stream_len,
	output snappy_pkg::formed_slice_t     slice,
	output logic                          slice_valid,
	output logic                          input_done
);
	import snappy_pkg::*;

	beat_t                  hold;        // last beat, waits for its lookahead
	logic                   busy;        // beats of the stream still expected
	logic                   last_pend;   // final beat taken, flush next cycle
	logic                   last_out;    // flushed slice is on the output
	logic [BEAT_CNT_W-1:0]  beat_cnt;    // beats taken so far
	logic [BEAT_CNT_W-1:0]  last_idx;    // index of the final beat
	logic [3:0]             len_tail;    // bytes used in the final beat, 0 = all
	logic                   take;
	logic                   is_last;

	assign take    = in_valid & busy;
	assign is_last = beat_cnt == last_idx;

	//////////////////////////////////////////////////////////////////////////////
	// stream control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy        <= 1'b0;
			last_pend   <= 1'b0;
			last_out    <= 1'b0;
			beat_cnt    <= '0;
			slice_valid <= 1'b0;
			input_done  <= 1'b1;   // idle
		end else begin
			slice_valid <= (take && beat_cnt != '0) || last_pend;   // first beat hidden
			last_pend   <= take && is_last;
			last_out    <= last_pend;
			if (start) begin
				busy     <= 1'b1;
				beat_cnt <= '0;
			end else if (take) begin
				busy     <= !is_last;
				beat_cnt <= beat_cnt + 1'b1;
			end
			if (start) begin
				input_done <= 1'b0;
			end else if (last_out) begin
				input_done <= 1'b1;   // cycle after the last slice left
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// slice data
	always_ff @(posedge clk) begin
		if (start) begin
			len_tail <= stream_len[3:0];
			// ceil(len / 16) - 1
			last_idx <= BEAT_CNT_W'(stream_len[LEN_W-1:4] + (stream_len[3:0] != 4'd0) - 1'b1);
		end
		if (take) begin
			hold <= in_beat;
		end
		if (last_pend) begin
			slice.data     <= {hold, {LOOKAHEAD_BYTES*8{1'b0}}};   // nothing follows
			slice.end_mask <= (len_tail == 4'd0) ? '1 : ~(pos_mask_t'('1) >> len_tail);
		end else if (take) begin
			slice.data     <= {hold, in_beat[BEAT_BYTES*8-1 -: LOOKAHEAD_BYTES*8]};
			slice.end_mask <= '1;
		end
	end

endmodule

`default_nettype wire

//--- logic/token_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module token_decoder (
	input  wire logic                       clk,
	input  wire snappy_pkg::formed_slice_t  slice,
	input  wire logic                       slice_valid,
	output snappy_pkg::decoded_slice_t      dec,
	output logic                            dec_valid
);
	import snappy_pkg::*;

	tok_guess_t [BEAT_BYTES-1:0] guess;   // one per start position

	// decode a tag sitting at byte pos of the slice
	function automatic tok_guess_t decode_tag(input logic [7:0] tag, input logic [7:0] nxt,
			input int pos);
		tok_guess_t g;
		int hdr;    // tag bytes
		int lit;    // literal data bytes, 0 for copies
		int stop;   // first byte past the token
		int room;   // data bytes still inside this beat
		hdr = int'(tag_bytes(tag));
		lit = 0;
		g.out_len = '0;
		if (tag == TAG_LIT_LEN1) begin
			lit = int'(nxt) + 1;
		end else if (tag[1:0] == TAG_COPY1) begin
			g.out_len = TOK_LEN_W'(tag[4:2]) + TOK_LEN_W'(4);   // 4..11
		end else if (tag[1:0] == TAG_COPY2) begin
			g.out_len = TOK_LEN_W'(tag[7:2]) + TOK_LEN_W'(1);   // 1..64
		end else begin
			lit = int'(tag[7:2]) + 1;
		end
		stop = pos + hdr + lit;
		room = BEAT_BYTES - pos - hdr;
		if (lit != 0) begin
			// only the literal bytes that land in this slice
			g.out_len = TOK_LEN_W'((lit < room) ? lit : ((room > 0) ? room : 0));
		end
		g.next_mask = (pos_mask_t'('1) >> pos) & ~(pos_mask_t'('1) >> stop);
		g.lit_carry = (lit != 0 && stop > BEAT_BYTES) ? LIT_CARRY_W'(stop - BEAT_BYTES) : '0;
		return g;
	endfunction

	//////////////////////////////////////////////////////////////////////////////
	// every byte decoded as a possible tag, looking at it and its follower
	for (genvar i = 0; i < BEAT_BYTES; i++) begin : g_byte
		assign guess[i] = decode_tag(slice.data[(SLICE_BYTES-i)*8-1 -: 8],
			slice.data[(SLICE_BYTES-i-1)*8-1 -: 8], i);
	end

	always_ff @(posedge clk) begin
		dec_valid <= slice_valid;   // low once the former is in reset
		dec.slc   <= slice;
		dec.guess <= guess;
	end

endmodule

`default_nettype wire

//--- logic/token_resolver.sv
`timescale 1ns/10ps
`default_nettype none

module token_resolver (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire logic                        start,
	input  wire snappy_pkg::decoded_slice_t  dec,
	input  wire logic                        dec_valid,
	output snappy_pkg::resolved_slice_t      res,
	output logic                             res_valid
);
	import snappy_pkg::*;

	logic [LIT_CARRY_W-1:0] lit_left;    // carried literal bytes still to come
	logic [1:0]             entry_la;    // bytes 0 and 1 owned by an earlier token
	logic                   lit_full;    // whole slice is literal data
	logic                   lit_hdr;     // byte 0 is the length byte of an F0 literal
	pos_mask_t              entry_cov;   // bytes taken before the walk starts
	pos_mask_t              covered;
	pos_mask_t              tok_pos;     // real token starts, before end mask
	logic [LIT_CARRY_W-1:0] lit_next;
	logic [1:0]             la_next;
	logic [7:0]             tag14;
	logic [7:0]             tag15;

	assign lit_full  = lit_left >= LIT_CARRY_W'(BEAT_BYTES);
	assign lit_hdr   = entry_la[1] & (lit_left != '0);
	assign entry_cov = lit_full ? '1
		: ~(pos_mask_t'('1) >> lit_left[3:0]) | {entry_la, {BEAT_BYTES-2{1'b0}}};

	//////////////////////////////////////////////////////////////////////////////
	// token chain, first free byte is a tag, its guess claims the bytes after it
	always_comb begin
		covered  = entry_cov;
		tok_pos  = '0;
		lit_next = '0;
		for (int j = 0; j < BEAT_BYTES; j++) begin
			if (!covered[BEAT_BYTES-1-j]) begin
				tok_pos[BEAT_BYTES-1-j] = 1'b1;
				covered  = covered | dec.guess[j].next_mask;
				lit_next = lit_next | dec.guess[j].lit_carry;   // only the last can spill
			end
		end
	end

	// tags at bytes 14 and 15 may reach into the lookahead
	assign tag14 = dec.slc.data[(SLICE_BYTES-14)*8-1 -: 8];
	assign tag15 = dec.slc.data[(SLICE_BYTES-15)*8-1 -: 8];
	assign la_next[1] = (tok_pos[0] && tag_bytes(tag15) >= 2'd2)
		|| (tok_pos[1] && tag_bytes(tag14) == 2'd3);
	assign la_next[0] = tok_pos[0] && tag_bytes(tag15) == 2'd3;

	//////////////////////////////////////////////////////////////////////////////
	// carried state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lit_left  <= '0;
			entry_la  <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= dec_valid;
			if (start) begin
				lit_left <= '0;   // byte 0 of a new stream is a tag
				entry_la <= '0;
			end else if (dec_valid) begin
				lit_left <= lit_full ? lit_left - LIT_CARRY_W'(BEAT_BYTES) : lit_next;
				entry_la <= la_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		res.data         <= dec.slc.data;
		res.token_pos    <= tok_pos & dec.slc.end_mask;
		res.start_lit    <= (lit_left != '0) & ~lit_hdr;
		res.lit_in_slice <= LIT_IN_W'(lit_full ? BEAT_BYTES : int'(lit_left[3:0]))
			- LIT_IN_W'(lit_hdr);
		for (int j = 0; j < BEAT_BYTES; j++) begin
			res.out_len[j] <= dec.guess[j].out_len;
		end
	end

endmodule

`default_nettype wire

//--- logic/address_accum.sv
`timescale 1ns/10ps
`default_nettype none

module address_accum (
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire logic                         start,
	input  wire snappy_pkg::resolved_slice_t  res,
	input  wire logic                         res_valid,
	output snappy_pkg::slice_out_t            out,
	output logic                              out_valid
);
	import snappy_pkg::*;

	logic [SUM_W-1:0] tok_len [BEAT_BYTES];   // masked per-byte length
	logic [SUM_W-1:0] lvl1 [8];
	logic [SUM_W-1:0] lvl2 [4];
	logic [SUM_W-1:0] lvl3 [2];
	logic [SUM_W-1:0] slice_sum;
	logic [SUM_W-1:0] sum_q;
	slice_data_t      data_q;
	pos_mask_t        pos_q;
	logic             lit_q;
	logic             valid_q;
	logic [2:0]       start_d;    // start trails the old stream down the pipe
	addr_t            run_addr;   // address of the next slice

	//////////////////////////////////////////////////////////////////////////////
	// sum tree
	always_comb begin
		for (int j = 0; j < BEAT_BYTES; j++) begin
			tok_len[j] = res.token_pos[BEAT_BYTES-1-j] ? SUM_W'(res.out_len[j]) : '0;
		end
		for (int k = 0; k < 8; k++) begin
			lvl1[k] = tok_len[2*k] + tok_len[2*k+1];
		end
		for (int k = 0; k < 4; k++) begin
			lvl2[k] = lvl1[2*k] + lvl1[2*k+1];
		end
		for (int k = 0; k < 2; k++) begin
			lvl3[k] = lvl2[2*k] + lvl2[2*k+1];
		end
		slice_sum = lvl3[0] + lvl3[1] + SUM_W'(res.lit_in_slice);   // plus carried literal
	end

	//////////////////////////////////////////////////////////////////////////////
	// accumulate
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q   <= 1'b0;
			out_valid <= 1'b0;
			start_d   <= '0;
			run_addr  <= '0;
		end else begin
			valid_q   <= res_valid;
			out_valid <= valid_q;
			start_d   <= {start_d[1:0], start};
			if (start_d[2]) begin
				run_addr <= '0;   // old stream has taken its last address
			end else if (valid_q) begin
				run_addr <= run_addr + ADDR_W'(sum_q);   // wraps at 2^17
			end
		end
	end

	always_ff @(posedge clk) begin
		sum_q         <= slice_sum;
		data_q        <= res.data;
		pos_q         <= res.token_pos;
		lit_q         <= res.start_lit;
		out.data      <= data_q;
		out.token_pos <= pos_q;
		out.start_lit <= lit_q;
		out.address   <= run_addr;   // before this slice's own sum
	end

endmodule

`default_nettype wire

//--- logic/preparser_top.sv
`timescale 1ns/10ps
`default_nettype none

module preparser_top (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire snappy_pkg::beat_t        in_beat,
	input  wire logic                     in_valid,
	input  wire logic                     start,
	input  wire snappy_pkg::stream_len_t  stream_len,
	output snappy_pkg::slice_out_t        out,
	output logic                          out_valid,
	output logic                          input_done
);
	import snappy_pkg::*;

	formed_slice_t   slice;         // beat plus lookahead
	logic            slice_valid;
	decoded_slice_t  dec;           // per-byte guesses
	logic            dec_valid;
	resolved_slice_t res;           // real token starts
	logic            res_valid;

	slice_former i_former (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_beat     (in_beat),
		.in_valid    (in_valid),
		.start       (start),
		.stream_len  (stream_len),
		.slice       (slice),
		.slice_valid (slice_valid),
		.input_done  (input_done)
	);

	token_decoder i_decoder (
		.clk         (clk),
		.slice       (slice),
		.slice_valid (slice_valid),
		.dec         (dec),
		.dec_valid   (dec_valid)
	);

	token_resolver i_resolver (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.dec       (dec),
		.dec_valid (dec_valid),
		.res       (res),
		.res_valid (res_valid)
	);

	address_accum i_accum (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.res       (res),
		.res_valid (res_valid),
		.out       (out),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int fail_cnt = 0;   // mismatches seen so far

// one mismatch
task automatic tb_fail(input string what);
	fail_cnt++;
	$display("CHECK FAILED at %0t: %s", $time, what);
endtask

task automatic check_mask(input string what, input snappy_pkg::pos_mask_t got,
		input snappy_pkg::pos_mask_t exp);
	if (got !== exp) begin
		tb_fail($sformatf("%s token_pos got %h exp %h", what, got, exp));
	end
endtask

task automatic check_addr(input string what, input snappy_pkg::addr_t got,
		input snappy_pkg::addr_t exp);
	if (got !== exp) begin
		tb_fail($sformatf("%s address got %0d exp %0d", what, got, exp));
	end
endtask

task automatic check_data(input string what, input snappy_pkg::slice_data_t got,
		input snappy_pkg::slice_data_t exp);
	if (got !== exp) begin
		tb_fail($sformatf("%s data got %h exp %h", what, got, exp));
	end
endtask

// single flags like start_lit and input_done
task automatic check_bit(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		tb_fail($sformatf("%s got %b exp %b", what, got, exp));
	end
endtask

`endif

//--- tb/tb_preparser.sv
`timescale 1ns/10ps
`default_nettype none

module tb_preparser;
	import snappy_pkg::*;

	`include "tb_checks.svh"

	localparam int RND_STREAMS   = 20;
	localparam int RND_MAX_BEATS = 8;    // random streams stay below 128 bytes
	localparam int TOTAL_BEATS   = 1 + 4 + 3 + 6 + 3 + RND_STREAMS * RND_MAX_BEATS;
	localparam int WATCHDOG_CYC  = TOTAL_BEATS * 4 + 200;

	logic        clk = 1'b0;
	logic        rst_n;
	beat_t       in_beat;
	logic        in_valid;
	logic        start;
	stream_len_t stream_len;
	slice_out_t  out;
	logic        out_valid;
	logic        input_done;

	int          cyc = 0;                   // cycle index, bumps at every rising edge
	logic [31:0] lcg_state = 32'hf64bf2a8;
	logic [7:0]  strm [$];                  // stream being built, byte 0 first
	slice_out_t  got_q [$];                 // slices seen on the output
	int          got_cyc [$];
	slice_data_t exp_data [$];              // model results, one per slice
	pos_mask_t   exp_mask [$];
	logic        exp_lit [$];
	addr_t       exp_addr [$];
	int          exp_cyc [$];
	slice_out_t  seen [$];                  // slices of the last compare, for extra checks

	preparser_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_beat    (in_beat),
		.in_valid   (in_valid),
		.start      (start),
		.stream_len (stream_len),
		.out        (out),
		.out_valid  (out_valid),
		.input_done (input_done)
	);

	always #2 clk = ~clk;   // 4 ns period

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			got_q.push_back(out);
			got_cyc.push_back(cyc);
		end
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		abort_run($sformatf("watchdog expired after %0d cycles, the run hangs", WATCHDOG_CYC));
	end

	//////////////////////////////////////////////////////////////////////////////
	// helpers
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic stop_on_error();
		if (fail_cnt != 0) begin
			abort_run("stopping at the first mismatch");
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rnd_below(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[31:8] % n[23:0]);   // low bits of an LCG are weak
	endfunction

	task automatic new_stream();
		strm.delete();
	endtask

	// literal of n data bytes, length in the tag or in the next byte
	task automatic add_lit(input int n, input logic long_form);
		if (long_form) begin
			strm.push_back(TAG_LIT_LEN1);
			strm.push_back(8'(n - 1));
		end else begin
			strm.push_back({6'(n - 1), 2'b00});   // n up to 60
		end
		repeat (n) strm.push_back(8'(rnd_below(256)));
	endtask

	task automatic add_copy1(input int len);   // len 4..11
		strm.push_back({3'(rnd_below(8)), 3'(len - 4), TAG_COPY1});
		strm.push_back(8'(rnd_below(256)));      // low offset byte
	endtask

	task automatic add_copy2(input int len);   // len 1..64
		strm.push_back({6'(len - 1), TAG_COPY2});
		repeat (2) strm.push_back(8'(rnd_below(256)));
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// reference model, walks the tokens of strm
	task automatic expect_stream();
		int          len;
		int          nb;
		int          p;
		int          n;
		int          cnt [];      // output bytes owed to each slice
		bit          is_tag [];
		bit          is_lit [];   // literal data byte
		logic [7:0]  tag;
		addr_t       addr;
		slice_data_t d;
		pos_mask_t   m;
		len    = strm.size();
		nb     = (len + 15) / 16;
		cnt    = new[nb];
		is_tag = new[nb * 16];
		is_lit = new[nb * 16];
		p      = 0;
		while (p < len) begin
			tag       = strm[p];
			is_tag[p] = 1'b1;
			if (tag == TAG_LIT_LEN1 || tag[1:0] == 2'b00) begin
				n = (tag == TAG_LIT_LEN1) ? int'(strm[p + 1]) + 1 : int'(tag[7:2]) + 1;
				p += (tag == TAG_LIT_LEN1) ? 2 : 1;
				for (int k = 0; k < n; k++) begin
					is_lit[p + k] = 1'b1;
					cnt[(p + k) / 16]++;   // data counts where it sits
				end
				p += n;
			end else if (tag[1:0] == TAG_COPY1) begin
				cnt[p / 16] += int'(tag[4:2]) + 4;   // counts in the tag's slice
				p += 2;
			end else begin
				cnt[p / 16] += int'(tag[7:2]) + 1;
				p += 3;
			end
		end
		addr = '0;
		for (int s = 0; s < nb; s++) begin
			for (int k = 0; k < SLICE_BYTES; k++) begin
				d[(SLICE_BYTES - k) * 8 - 1 -: 8] = (16 * s + k < len) ? strm[16 * s + k] : 8'h00;
			end
			for (int k = 0; k < BEAT_BYTES; k++) begin
				m[BEAT_BYTES - 1 - k] = is_tag[16 * s + k];   // tags past the end never set
			end
			exp_data.push_back(d);
			exp_mask.push_back(m);
			exp_lit.push_back(is_lit[16 * s]);
			exp_addr.push_back(addr);
			addr = addr + ADDR_W'(cnt[s]);   // wraps at 2^17
		end
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// driver
	function automatic int gap_cycles(input int mode, input int idx);
		if (mode == 1) begin
			return idx % 3;
		end
		if (mode == 2) begin
			return (rnd_below(3) == 0) ? 1 : 0;
		end
		return 0;
	endfunction

	task automatic send_stream(input int gap_mode);
		int    len;
		int    nb;
		beat_t b;
		len = strm.size();
		nb  = (len + 15) / 16;
		@(posedge clk);
		#1;
		check_bit("input_done before start", input_done, 1'b1);
		stop_on_error();
		start      = 1'b1;
		stream_len = stream_len_t'(len);
		@(posedge clk);
		#1;
		start = 1'b0;
		check_bit("input_done after start", input_done, 1'b0);
		stop_on_error();
		for (int i = 0; i < nb; i++) begin
			repeat (gap_cycles(gap_mode, i)) begin
				in_valid = 1'b0;
				in_beat  = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};   // junk
				@(posedge clk);
				#1;
			end
			for (int k = 0; k < BEAT_BYTES; k++) begin
				b[(BEAT_BYTES - k) * 8 - 1 -: 8] = (16 * i + k < len) ? strm[16 * i + k] : 8'h00;
			end
			in_beat  = b;
			in_valid = 1'b1;
			if (i > 0) begin
				exp_cyc.push_back(cyc + 5);   // this beat completes the slice before it
			end
			if (i == nb - 1) begin
				exp_cyc.push_back(cyc + 6);   // flushed one cycle later
			end
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
		@(posedge clk);
		#1;
		check_bit("input_done while the last slice leaves", input_done, 1'b0);
		stop_on_error();
		@(posedge clk);
		#1;
		check_bit("input_done after the last slice", input_done, 1'b1);
		stop_on_error();
	endtask

	// wait for every expected slice, then compare in order
	task automatic check_outputs(input string name);
		int         waited;
		int         gc;
		int         ec;
		string      what;
		slice_out_t g;
		waited = 0;
		while (got_q.size() < exp_data.size()) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > 40) begin
				abort_run($sformatf("%s: only %0d of %0d slices came out", name,
					got_q.size(), exp_data.size()));
			end
		end
		seen.delete();
		for (int i = 0; exp_data.size() != 0; i++) begin
			g    = got_q.pop_front();
			gc   = got_cyc.pop_front();
			ec   = exp_cyc.pop_front();
			what = $sformatf("%s slice %0d", name, i);
			check_data(what, g.data, exp_data.pop_front());
			stop_on_error();
			check_mask(what, g.token_pos, exp_mask.pop_front());
			stop_on_error();
			check_bit({what, " start_lit"}, g.start_lit, exp_lit.pop_front());
			stop_on_error();
			check_addr(what, g.address, exp_addr.pop_front());
			stop_on_error();
			if (gc != ec) begin
				abort_run($sformatf("%s: out_valid came in cycle %0d instead of cycle %0d",
					what, gc, ec));
			end
			seen.push_back(g);
		end
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// directed tests
	task automatic single_literal();
		new_stream();
		add_lit(5, 1'b0);   // 6 bytes, rest of the beat is padding
		expect_stream();
		send_stream(0);
		check_outputs("single literal");
		check_mask("single literal", seen[0].token_pos, 16'h8000);   // padding masked
		stop_on_error();
		check_addr("single literal", seen[0].address, '0);
		stop_on_error();
	endtask

	task automatic long_literal();
		new_stream();
		add_lit(60, 1'b1);   // F0 literal over four slices
		add_copy1(7);
		expect_stream();
		send_stream(0);
		check_outputs("long literal");
		for (int s = 1; s < 3; s++) begin
			check_bit("long literal start_lit", seen[s].start_lit, 1'b1);
			stop_on_error();
			check_mask("long literal inner", seen[s].token_pos, '0);
			stop_on_error();
			// 14 data bytes in slice 0, then 16 in every inner slice
			check_addr("long literal step", seen[s + 1].address, addr_t'(14 + 16 * s));
			stop_on_error();
		end
	endtask

	task automatic copies_at_slice_end();
		new_stream();
		add_lit(13, 1'b0);   // bytes 0..13
		add_copy2(8);        // tag at byte 14, one byte spills
		add_lit(13, 1'b0);   // bytes 17..30
		add_copy2(40);       // tag at byte 31, two bytes spill
		add_lit(1, 1'b0);    // tag at byte 34
		expect_stream();
		send_stream(0);
		check_outputs("copies at slice end");
		check_mask("copy2 at byte 14", seen[0].token_pos, 16'h8002);
		stop_on_error();
		check_mask("entry at byte 1", seen[1].token_pos, 16'h4001);
		stop_on_error();
		check_mask("entry at byte 2", seen[2].token_pos, 16'h2000);
		stop_on_error();
	endtask

	task automatic mixed_with_gaps();
		new_stream();
		add_copy1(6);
		add_lit(3, 1'b0);
		add_copy2(20);
		add_lit(20, 1'b1);
		add_copy1(11);
		add_lit(9, 1'b0);
		add_copy2(64);
		add_lit(30, 1'b1);
		add_copy1(4);
		add_lit(1, 1'b0);   // 82 bytes, 6 beats
		expect_stream();
		send_stream(1);
		check_outputs("mixed with gaps");
	endtask

	task automatic two_streams();
		new_stream();
		add_lit(10, 1'b0);
		add_copy2(33);
		expect_stream();
		send_stream(0);
		new_stream();       // starts right after input_done rises
		add_lit(20, 1'b1);
		add_copy1(5);
		expect_stream();
		send_stream(0);
		check_outputs("two streams");
		check_addr("second stream restart", seen[1].address, '0);
		stop_on_error();
	endtask

	task automatic random_streams();
		int target;
		for (int r = 0; r < RND_STREAMS; r++) begin
			new_stream();
			target = 1 + rnd_below(100);
			while (strm.size() < target) begin
				case (rnd_below(4))
					0:       add_lit(1 + rnd_below(20), 1'b0);
					1:       add_lit(1 + rnd_below(26), 1'b1);
					2:       add_copy1(4 + rnd_below(8));
					default: add_copy2(1 + rnd_below(64));
				endcase
			end
			expect_stream();
			send_stream(2);
			check_outputs($sformatf("random stream %0d", r));
		end
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// main sequence
	initial begin
		rst_n      = 1'b0;
		in_beat    = '0;
		in_valid   = 1'b0;
		start      = 1'b0;
		stream_len = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		single_literal();
		long_literal();
		copies_at_slice_end();
		mixed_with_gaps();
		two_streams();
		random_streams();
		repeat (10) @(posedge clk);   // catch stray slices
		if (fail_cnt != 0 || got_q.size() != 0) begin
			abort_run($sformatf("%0d mismatches, %0d slices nobody asked for", fail_cnt,
				got_q.size()));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
logic/snappy_pkg.sv
logic/slice_former.sv
logic/token_decoder.sv
logic/token_resolver.sv
logic/address_accum.sv
logic/preparser_top.sv
tb/tb_preparser.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f all.f --top-module tb_preparser -Mdir obj_dir \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_preparser > sim.log 2>&1 || true
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || { echo "no verdict in sim.log"; exit 1; }
exit 0
